//--- top.f
+incdir+src
src/wb_pkg.sv
src/rec_pkg.sv
src/wb_if.sv
src/mem_req_if.sv
src/sram_wb_wrapper.sv
src/wb_manager.sv
src/rec_ctrl.sv
src/team_06.sv
src/top.sv
sim/tb_top.sv

//--- sim/tb_top.sv
`include "rec_consts.svh"

module tb_top;

  timeunit 1ns;
  timeprecision 1ps;

  // Command codes used in the table
  localparam logic [1:0] CMD_REC  = 2'd0;
  localparam logic [1:0] CMD_PLAY = 2'd1;
  localparam logic [1:0] CMD_CLR  = 2'd2;

  // Cycle counts per command
  localparam int HOLD_CYCLES   = 4;
  localparam int REQ_LATENCY   = 2;
  localparam int SETTLE_CYCLES = 2;
  localparam int BUSY_TIMEOUT  = 50;

  // Samples played back after the full fill
  localparam int REPLAY_COUNT = 5;

  // One table entry, command plus expected board outputs
  typedef struct packed {
    logic [1:0] cmd;
    logic [7:0] data;
    logic [7:0] exp_left;
    logic [8:0] exp_count;
  } step_t;

  logic        clk;
  logic        rst_n;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic        red;
  logic        green;
  logic        blue;

  step_t       steps [0:15];
  int          n_steps;
  logic [31:0] rnd_state;
  // Reference copy of the buffer for the full fill
  logic [7:0]  model [`REC_DEPTH];

  top u_top (
    .hwclk_i (clk),
    .rst_n_i (rst_n),
    .pb_i    (pb),
    .left_o  (left),
    .right_o (right),
    .red_o   (red),
    .green_o (green),
    .blue_o  (blue)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // 32-bit xorshift, shifts 13, 17, 5
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Lands 2 ns after the n-th rising edge
  task automatic next_cycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Output mismatch on %s", name);
    end
  endtask

  // Poll red_o once per cycle until the bus is idle
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (red !== 1'b0) begin
      next_cycles(1);
      cycles++;
      if (cycles > BUSY_TIMEOUT) begin
        $display("Bus still busy %0d cycles after the command", cycles);
        $display("TESTS FAILED");
        $fatal(1, "Busy timeout");
      end
    end
  endtask

  // Press one button with the sample on pb[7:0], then wait out the access
  task automatic run_command(input logic [1:0] cmd, input logic [7:0] data,
                             input logic exp_busy);
    int bit_pos;
    case (cmd)
      CMD_REC:  bit_pos = `PB_REC;
      CMD_PLAY: bit_pos = `PB_PLAY;
      default:  bit_pos = `PB_CLR;
    endcase
    pb[7:0]     = data;
    pb[bit_pos] = 1'b1;
    next_cycles(HOLD_CYCLES);
    pb[bit_pos] = 1'b0;
    // Two sync flops and the edge flop, then busy is up
    next_cycles(REQ_LATENCY);
    check_value("red_o", red, exp_busy);
    wait_idle();
    next_cycles(SETTLE_CYCLES);
  endtask

  task automatic add_step(input logic [1:0] cmd, input logic [7:0] data,
                          input logic [7:0] exp_left, input logic [8:0] exp_count);
    steps[n_steps].cmd       = cmd;
    steps[n_steps].data      = data;
    steps[n_steps].exp_left  = exp_left;
    steps[n_steps].exp_count = exp_count;
    n_steps++;
  endtask

  task automatic build_table();
    n_steps = 0;
    // Three records, left_o untouched
    add_step(CMD_REC,  8'h3c, 8'h00, 9'd1);
    add_step(CMD_REC,  8'ha5, 8'h00, 9'd2);
    add_step(CMD_REC,  8'h7e, 8'h00, 9'd3);
    // Playback in order
    add_step(CMD_PLAY, 8'h00, 8'h3c, 9'd3);
    add_step(CMD_PLAY, 8'h00, 8'ha5, 9'd3);
    add_step(CMD_PLAY, 8'h00, 8'h7e, 9'd3);
    // Past the last sample, back to the first
    add_step(CMD_PLAY, 8'h00, 8'h3c, 9'd3);
    // Clear keeps the last played value on left_o
    add_step(CMD_CLR,  8'h00, 8'h3c, 9'd0);
    add_step(CMD_REC,  8'hc3, 8'h3c, 9'd1);
    add_step(CMD_PLAY, 8'h00, 8'hc3, 9'd1);
    // Single sample wraps onto itself
    add_step(CMD_PLAY, 8'h00, 8'hc3, 9'd1);
  endtask

  initial begin
    rst_n     = 1'b0;
    pb        = '0;
    rnd_state = 32'h1d1f_e666;
    build_table();

    // Reset for 10 cycles
    next_cycles(10);
    rst_n = 1'b1;
    next_cycles(1);

    // Idle outputs after reset
    check_value("left_o", left, 8'h00);
    check_value("right_o", right, 8'h00);
    check_value("red_o", red, 1'b0);
    check_value("green_o", green, 1'b0);
    check_value("blue_o", blue, 1'b0);

    // Table walk, clear starts no bus access
    for (int s = 0; s < n_steps; s++) begin
      run_command(steps[s].cmd, steps[s].data, steps[s].cmd != CMD_CLR);
      check_value("left_o", left, steps[s].exp_left);
      check_value("right_o", right, steps[s].exp_count[7:0]);
      // Green only after a play result
      check_value("green_o", green, steps[s].cmd == CMD_PLAY);
      check_value("blue_o", blue, 1'b0);
    end

    // Full fill from the xorshift stream
    run_command(CMD_CLR, 8'h00, 1'b0);
    check_value("right_o", right, 8'h00);
    for (int k = 0; k < `REC_DEPTH; k++) begin
      rnd_state = xorshift32(rnd_state);
      model[k]  = rnd_state[7:0];
      run_command(CMD_REC, model[k], 1'b1);
      // right_o shows only the low byte of the count
      check_value("right_o", right, (k + 1) & 8'hff);
      check_value("blue_o", blue, (k + 1) == `REC_DEPTH);
    end

    // Record on a full buffer is dropped, bus stays idle
    rnd_state = xorshift32(rnd_state);
    run_command(CMD_REC, rnd_state[7:0], 1'b0);
    check_value("right_o", right, `REC_DEPTH & 8'hff);
    check_value("blue_o", blue, 1'b1);

    // Pointer restarted by the clear, so playback starts at slot 0
    for (int k = 0; k < REPLAY_COUNT; k++) begin
      run_command(CMD_PLAY, 8'h00, 1'b1);
      check_value("left_o", left, model[k]);
      check_value("green_o", green, 1'b1);
      check_value("blue_o", blue, 1'b1);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- src/top.sv
module top import wb_pkg::*; (
  input  logic        hwclk_i,
  input  logic        rst_n_i,
  input  logic [20:0] pb_i,
  output logic [7:0]  left_o,
  output logic [7:0]  right_o,
  output logic        red_o,
  output logic        green_o,
  output logic        blue_o
);

  logic [33:0] gpio_in;
  logic [33:0] gpio_out;

  // Bus between team design and SRAM
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_dat_t dat_r;
  wb_sel_t sel;
  logic    we;
  logic    stb;
  logic    cyc;
  logic    ack;

  wb_if u_sram_bus ();

  // Buttons on the low GPIO inputs
  assign gpio_in = {13'b0, pb_i};

  team_06 u_team_06 (
    .clk_i      (hwclk_i),
    .rst_n_i    (rst_n_i),
    .gpio_in_i  (gpio_in),
    .gpio_out_o (gpio_out),
    .adr_o      (adr),
    .dat_o      (dat_w),
    .sel_o      (sel),
    .we_o       (we),
    .stb_o      (stb),
    .cyc_o      (cyc),
    .dat_i      (dat_r),
    .ack_i      (ack)
  );

  // Master wires onto the SRAM slave port
  assign u_sram_bus.adr   = adr;
  assign u_sram_bus.dat_w = dat_w;
  assign u_sram_bus.sel   = sel;
  assign u_sram_bus.we    = we;
  assign u_sram_bus.stb   = stb;
  assign u_sram_bus.cyc   = cyc;
  assign dat_r            = u_sram_bus.dat_r;
  assign ack              = u_sram_bus.ack;

  sram_wb_wrapper u_sram (
    .clk_i   (hwclk_i),
    .rst_n_i (rst_n_i),
    .wb      (u_sram_bus.slave)
  );

  // GPIO out to board LEDs and displays
  assign left_o  = gpio_out[7:0];
  assign right_o = gpio_out[15:8];
  assign red_o   = gpio_out[16];
  assign green_o = gpio_out[17];
  assign blue_o  = gpio_out[18];

endmodule

//--- src/team_06.sv
`include "rec_consts.svh"

module team_06 import wb_pkg::*, rec_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [33:0] gpio_in_i,
  output logic [33:0] gpio_out_o,
  // Wishbone master
  output wb_adr_t     adr_o,
  output wb_dat_t     dat_o,
  output wb_sel_t     sel_o,
  output logic        we_o,
  output logic        stb_o,
  output logic        cyc_o,
  input  wb_dat_t     dat_i,
  input  logic        ack_i
);

  // clr, play, rec, then the sample byte
  logic [10:0] raw;
  logic [10:0] sync1_q;
  logic [10:0] sync2_q;
  logic [2:0]  btn_q;
  logic [2:0]  pulse;

  sample_t play_data;
  logic    play_vld;
  count_t  count;
  logic    full;

  // Registered board outputs
  sample_t    left_q;
  logic [7:0] right_q;
  logic       red_q;
  logic       green_q;
  logic       blue_q;

  wb_if      u_wb ();
  mem_req_if u_req ();

  assign raw = {gpio_in_i[`PB_CLR], gpio_in_i[`PB_PLAY], gpio_in_i[`PB_REC],
                gpio_in_i[7:0]};

  // Two-flop synchronizer, then edge flop for the buttons
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      btn_q   <= '0;
    end else begin
      sync1_q <= raw;
      sync2_q <= sync1_q;
      btn_q   <= sync2_q[10:8];
    end
  end

  // Rising edge pulses
  assign pulse = sync2_q[10:8] & ~btn_q;

  rec_ctrl u_rec_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rec_i       (pulse[0]),
    .play_i      (pulse[1]),
    .clr_i       (pulse[2]),
    .sample_i    (sync2_q[7:0]),
    .mem         (u_req.controller),
    .play_data_o (play_data),
    .play_vld_o  (play_vld),
    .count_o     (count),
    .full_o      (full)
  );

  wb_manager u_wb_manager (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req     (u_req.manager),
    .wb      (u_wb.master)
  );

  // Output registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      left_q  <= '0;
      right_q <= '0;
      red_q   <= 1'b0;
      green_q <= 1'b0;
      blue_q  <= 1'b0;
    end else begin
      if (play_vld) begin
        left_q <= play_data;
      end
      right_q <= count[7:0];
      red_q   <= u_req.busy;
      blue_q  <= full;
      // Held from play result until next button
      if (play_vld) begin
        green_q <= 1'b1;
      end else if (|pulse) begin
        green_q <= 1'b0;
      end
    end
  end

  assign gpio_out_o = {15'b0, blue_q, green_q, red_q, right_q, left_q};

  // Bus out as plain ports
  assign adr_o       = u_wb.adr;
  assign dat_o       = u_wb.dat_w;
  assign sel_o       = u_wb.sel;
  assign we_o        = u_wb.we;
  assign stb_o       = u_wb.stb;
  assign cyc_o       = u_wb.cyc;
  assign u_wb.dat_r  = dat_i;
  assign u_wb.ack    = ack_i;

endmodule

//--- src/rec_ctrl.sv
`include "rec_consts.svh"

module rec_ctrl import rec_pkg::*, wb_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 rec_i,
  input  logic                 play_i,
  input  logic                 clr_i,
  input  sample_t              sample_i,
  mem_req_if.controller        mem,
  output sample_t              play_data_o,
  output logic                 play_vld_o,
  output count_t               count_o,
  output logic                 full_o
);

  rec_state_t state;

  // Samples stored and next sample to play
  count_t count;
  count_t ptr;
  count_t ptr_next;

  logic               busy_q;
  logic               done;
  logic               full;
  logic               wr_go;
  logic               rd_go;
  logic [`REC_AW-1:0] word_sel;

  assign full     = (count == count_t'(`REC_DEPTH));
  assign ptr_next = ptr + count_t'(1);

  // Falling edge of busy ends a request
  assign done = busy_q & ~mem.busy;

  // Issue conditions in idle
  // clear beats record, record beats play
  assign wr_go = (state == ST_IDLE) & ~mem.busy & ~clr_i & rec_i & ~full;
  assign rd_go = (state == ST_IDLE) & ~mem.busy & ~clr_i & ~rec_i & play_i
               & (count != '0);

  // Slot for the next write or read
  assign word_sel = wr_go ? count[`REC_AW-1:0] : ptr[`REC_AW-1:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= mem.busy;
    end
  end

  // Controller FSM
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state  <= ST_IDLE;
      count  <= '0;
      ptr    <= '0;
      mem.wr <= 1'b0;
      mem.rd <= 1'b0;
    end else begin
      // Strobes last one cycle
      mem.wr <= wr_go;
      mem.rd <= rd_go;
      case (state)
        ST_IDLE: begin
          if (clr_i) begin
            count <= '0;
            ptr   <= '0;
          end else if (wr_go) begin
            state <= ST_WR_WAIT;
          end else if (rd_go) begin
            state <= ST_RD_WAIT;
          end
        end
        ST_WR_WAIT: begin
          // Sample stored, claim the slot
          if (done) begin
            count <= count + count_t'(1);
            state <= ST_IDLE;
          end
        end
        ST_RD_WAIT: begin
          // Wrap back to the first sample after the last
          if (done) begin
            ptr   <= (ptr_next == count) ? '0 : ptr_next;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request payload, byte address is slot times 4
  always_ff @(posedge clk_i) begin
    if (wr_go || rd_go) begin
      mem.adr   <= wb_adr_t'({word_sel, 2'b00});
      mem.wdata <= wb_dat_t'(sample_i);
    end
  end

  // Low byte of the read word
  assign play_data_o = mem.rdata[7:0];
  assign play_vld_o  = (state == ST_RD_WAIT) & done;

  assign count_o = count;
  assign full_o  = full;

endmodule

//--- src/wb_manager.sv
module wb_manager import wb_pkg::*; (
  input logic        clk_i,
  input logic        rst_n_i,
  mem_req_if.manager req,
  wb_if.master       wb
);

  // Cycle control
  logic busy_q;
  logic cyc_q;
  logic stb_q;
  logic we_q;

  // Latched request payload
  wb_adr_t adr_q;
  wb_dat_t dat_w_q;
  wb_sel_t sel_q;

  // Read result
  wb_dat_t rdata_q;

  logic start;

  // Strobes only count while idle
  assign start = ~busy_q & (req.wr | req.rd);

  // Bus cycle state
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cyc_q  <= 1'b0;
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
    end else if (start) begin
      // cyc and stb rise together
      busy_q <= 1'b1;
      cyc_q  <= 1'b1;
      stb_q  <= 1'b1;
      we_q   <= req.wr;
    end else if (busy_q && wb.ack) begin
      // End of cycle on ack
      busy_q <= 1'b0;
      cyc_q  <= 1'b0;
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
    end
  end

  // Payload held stable for the whole cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      adr_q   <= req.adr;
      dat_w_q <= req.wdata;
      // Lane picked by the low address bits
      sel_q   <= wb_sel_t'(1) << req.adr[WB_WORD_LSB-1:0];
    end
  end

  // Read data captured with ack
  always_ff @(posedge clk_i) begin
    if (busy_q && wb.ack && !we_q) begin
      rdata_q <= wb.dat_r;
    end
  end

  assign wb.adr   = adr_q;
  assign wb.dat_w = dat_w_q;
  assign wb.sel   = sel_q;
  assign wb.we    = we_q;
  assign wb.stb   = stb_q;
  assign wb.cyc   = cyc_q;

  assign req.busy  = busy_q;
  assign req.rdata = rdata_q;

endmodule

//--- src/sram_wb_wrapper.sv
`include "rec_consts.svh"

module sram_wb_wrapper import wb_pkg::*; (
  input logic clk_i,
  input logic rst_n_i,
  wb_if.slave wb
);

  // Word array, one entry per sample slot
  wb_dat_t mem [`REC_DEPTH];

  logic [`REC_AW-1:0] word_idx;
  logic               ack_q;
  logic               access;
  wb_dat_t            dat_r_q;

  // Word index from byte address bits 9 to 2
  assign word_idx = wb.adr[WB_WORD_LSB +: `REC_AW];

  // New request, not yet acked
  assign access = wb.stb & wb.cyc & ~ack_q;

  // Single-cycle ack, one cycle after stb and cyc
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Array write per byte lane, read data registered
  always_ff @(posedge clk_i) begin
    if (access) begin
      for (int i = 0; i < WB_SEL_W; i++) begin
        if (wb.we && wb.sel[i]) begin
          mem[word_idx][8*i +: 8] <= wb.dat_w[8*i +: 8];
        end
      end
      // Old contents on a write, unused by the master
      dat_r_q <= mem[word_idx];
    end
  end

  assign wb.ack   = ack_q;
  assign wb.dat_r = dat_r_q;

endmodule

//--- src/mem_req_if.sv
interface mem_req_if import wb_pkg::*;;

  // Single-cycle strobes from the controller
  logic    wr;
  logic    rd;
  wb_adr_t adr;
  wb_dat_t wdata;

  // Result and status from the bus master
  wb_dat_t rdata;
  logic    busy;

  modport controller (
    output wr, rd, adr, wdata,
    input  rdata, busy
  );

  modport manager (
    input  wr, rd, adr, wdata,
    output rdata, busy
  );

endinterface

//--- src/wb_if.sv
interface wb_if import wb_pkg::*;;

  // Master to slave
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_sel_t sel;
  logic    we;
  logic    stb;
  logic    cyc;

  // Slave to master
  wb_dat_t dat_r;
  logic    ack;

  // Bus master side
  modport master (
    output adr, dat_w, sel, we, stb, cyc,
    input  dat_r, ack
  );

  // Memory side
  modport slave (
    input  adr, dat_w, sel, we, stb, cyc,
    output dat_r, ack
  );

endinterface

//--- src/rec_pkg.sv
`include "rec_consts.svh"

package rec_pkg;

  // One button sample
  typedef logic [7:0] sample_t;

  // Count or pointer, one bit wider than the word index
  // so a full buffer of REC_DEPTH fits
  typedef logic [`REC_AW:0] count_t;

  // Controller FSM
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    // Write issued, waiting on busy to fall
    ST_WR_WAIT = 2'd1,
    // Read issued, waiting on busy to fall
    ST_RD_WAIT = 2'd2
  } rec_state_t;

endpackage

//--- src/wb_pkg.sv
package wb_pkg;

  // Bus widths
  localparam int WB_ADR_W = 32;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = WB_DAT_W / 8;

  // Lowest address bit of the word index
  localparam int WB_WORD_LSB = 2;

  // Byte address as seen on the bus
  typedef logic [WB_ADR_W-1:0] wb_adr_t;

  // One data word, read or write
  typedef logic [WB_DAT_W-1:0] wb_dat_t;

  // One bit per byte lane
  typedef logic [WB_SEL_W-1:0] wb_sel_t;

endpackage

//--- src/rec_consts.svh
`ifndef REC_CONSTS_SVH
`define REC_CONSTS_SVH

// Buffer depth in samples and its log2
`define REC_DEPTH 256
`define REC_AW 8

// Push button bit numbers
`define PB_REC 16
`define PB_PLAY 17
`define PB_CLR 18

`endif
